/* decode_testdata.txt */
# name uuid wid tmask pc instr | expected: ex_type op_type op_args wb rd rs1 rs2 rs3 is_wstall
# all columns after the name are hex; op_args is the 36-bit argument word
addi 01 0 f 00001000 00510093 0 0 100000005 1 01 02 00 00 0
sub 02 1 3 00001004 405201b3 0 1 000000000 1 03 04 05 00 0
srai 03 2 5 00001008 4033d313 0 7 100000003 1 06 07 00 00 0
lui 04 3 f 0000100c 12345437 0 a 112345000 1 08 00 00 00 0
auipc 05 0 1 00001010 fffff497 0 b 3fffff000 1 09 00 00 00 0
mul 06 1 f 00001014 02c58533 0 0 800000000 1 0a 0b 0c 00 0
divu 07 2 a 00001018 02f756b3 0 5 800000000 1 0d 0e 0f 00 0
beq 08 3 f 0000101c fe208ce3 0 0 7fffffff8 0 00 01 02 00 1
bltu 09 0 c 00001020 0041e863 0 4 700000010 0 00 03 04 00 1
jal 0a 1 f 00001024 001000ef 0 6 700000800 1 01 00 00 00 1
jalr 0b 2 f 00001028 00008067 0 7 500000000 0 00 01 00 00 1
ecall 0c 3 f 0000102c 00000073 0 8 700000004 0 00 00 00 00 1
mret 0d 0 f 00001030 30200073 0 c 700000004 0 00 00 00 00 1
lw 0e 1 f 00001034 ffc32283 1 2 7fe000000 1 05 06 00 00 0
lbu_x0 0f 2 3 00001038 0080c003 1 4 004000000 0 00 01 00 00 0
sw 10 3 f 0000103c 00742a23 1 a 80a000000 0 00 08 07 00 0
fence 11 0 f 00001040 0ff0000f 1 f 000000000 0 00 00 00 00 0
csrrs 12 1 f 00001044 002022f3 2 7 002000000 1 05 00 00 00 1
csrrwi 13 2 f 00001048 3002d073 2 6 300940000 0 00 00 00 00 0
csrrc 14 3 f 0000104c 003130f3 2 8 003000000 1 01 02 00 00 1
tmc 15 0 f 00001050 0001800b 2 0 000000000 0 00 03 00 00 1
split 16 1 f 00001054 0012a20b 2 2 800000000 1 04 05 00 00 1
pred 17 2 f 00001058 0073508b 2 5 800000000 0 00 06 07 00 1
bar 18 3 f 0000105c 0020c00b 2 4 000000000 0 00 01 02 00 1
unknown 19 0 f 00001060 ffffffff 0 0 000000000 0 00 00 00 00 0
ext1_bad 1a 1 f 00001064 0020e08b 0 0 000000000 0 00 00 00 00 0

/* gpu_decode.f */
+incdir+.
gpu_decode_pkg.sv
imm_gen.sv
func_decode.sv
instr_decoder.sv
decode_buffer.sv
decode_stage.sv
decode_stage_checker.sv
decode_stage_tb.sv

/* Bender.yml */
package:
  name: gpu_decode

sources:
  - include_dirs:
      - .
    files:
      - gpu_decode_pkg.sv
      - imm_gen.sv
      - func_decode.sv
      - instr_decoder.sv
      - decode_buffer.sv
      - decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - decode_stage_checker.sv
      - decode_stage_tb.sv

/* decode_stage_tb.sv */
// Decode stage testbench
`timescale 1ns/1ps
`include "gpu_decode_consts.svh"

module decode_stage_tb;

    import gpu_decode_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 10;
    localparam int CYCLES_PER_VEC = 40;

    logic         clk;
    logic         rst;
    logic         fetch_valid;
    logic         fetch_ready;
    fetch_data_t  fetch_data;
    logic         decode_valid;
    logic         decode_ready;
    decode_data_t decode_data;
    logic         sched_valid;
    sched_info_t  sched;

    fetch_data_t  vec_in[$];
    decode_data_t vec_out[$];
    logic         vec_stall[$];
    string        vec_name[$];
    decode_data_t exp_q[$];
    string        exp_name[$];

    int sent;
    int received;
    bit pending;
    bit loaded;
    int decode_errors;
    int sched_errors;
    int other_errors;
    int seed;

    decode_stage DUT (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_data   (fetch_data),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode_data  (decode_data),
        .sched_valid  (sched_valid),
        .sched        (sched)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_vectors();
        int           fd;
        int           code;
        string        line;
        string        name;
        logic [35:0]  v [14];
        fetch_data_t  fin;
        decode_data_t dout;

        fd = $fopen("decode_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open decode_testdata.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                           v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                           v[10], v[11], v[12], v[13]);
            if (code != 15) begin
                $display("Malformed line in decode_testdata.txt: %s", line);
                other_errors++;
                continue;
            end
            fin.uuid      = v[0][`UUID_BITS-1:0];
            fin.wid       = v[1][`NW_BITS-1:0];
            fin.tmask     = v[2][`NUM_THREADS-1:0];
            fin.pc        = v[3][`XLEN-1:0];
            fin.instr     = v[4][31:0];
            // Pass-through fields come straight from the fetched item
            dout.uuid     = fin.uuid;
            dout.wid      = fin.wid;
            dout.tmask    = fin.tmask;
            dout.pc       = fin.pc;
            dout.ex_type  = v[5][`EX_BITS-1:0];
            dout.op_type  = v[6][`OP_BITS-1:0];
            dout.op_args  = v[7];
            dout.wb       = v[8][0];
            dout.rd       = v[9][`NR_BITS-1:0];
            dout.rs1      = v[10][`NR_BITS-1:0];
            dout.rs2      = v[11][`NR_BITS-1:0];
            dout.rs3      = v[12][`NR_BITS-1:0];
            vec_in.push_back(fin);
            vec_out.push_back(dout);
            vec_stall.push_back(v[13][0]);
            vec_name.push_back(name);
        end
        $fclose(fd);
    endtask

    task automatic check_decode(input string name, input decode_data_t exp,
                                input decode_data_t act);
        if (act !== exp) begin
            decode_errors++;
            $display("MISMATCH %s decode_data expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_sched(input string name, input sched_info_t exp,
                               input sched_info_t act);
        if (act !== exp) begin
            sched_errors++;
            $display("MISMATCH %s sched expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic drive_cycle();
        if (!pending) begin
            if (sent < vec_in.size() && ($urandom % 4) != 0) begin
                fetch_valid = 1'b1;
                fetch_data  = vec_in[sent];
                pending     = 1'b1;
            end else begin
                fetch_valid = 1'b0;
                fetch_data  = '0;
            end
        end
        decode_ready = (($urandom % 2) == 0);
    endtask

    // Handshakes are settled here and hold until the next rising edge
    task automatic observe_cycle();
        sched_info_t  exp_sched;
        decode_data_t exp_data;
        string        name;

        // Items in flight are exactly the two-entry buffer contents
        if (fetch_ready !== (exp_q.size() < 2)) begin
            $display("fetch_ready is wrong with %0d items in the buffer", exp_q.size());
            other_errors++;
        end
        if (decode_valid !== (exp_q.size() != 0)) begin
            $display("decode_valid is wrong with %0d items in the buffer", exp_q.size());
            other_errors++;
        end
        if (decode_valid && decode_ready) begin
            if (exp_q.size() == 0) begin
                $display("Decode output transfer with no item in flight");
                other_errors++;
            end else begin
                exp_data = exp_q.pop_front();
                name     = exp_name.pop_front();
                check_decode(name, exp_data, decode_data);
                received++;
            end
        end
        if (sched_valid !== (fetch_valid && fetch_ready)) begin
            $display("Scheduler valid does not follow the fetch transfer");
            other_errors++;
        end
        if (fetch_valid && fetch_ready) begin
            exp_sched.wid       = vec_in[sent].wid;
            exp_sched.is_wstall = vec_stall[sent];
            check_sched(vec_name[sent], exp_sched, sched);
            exp_q.push_back(vec_out[sent]);
            exp_name.push_back(vec_name[sent]);
            sent++;
            pending = 1'b0;
        end
    endtask

    task automatic report_results();
        int total;

        total = decode_errors + sched_errors + other_errors + DUT.u_checker.assert_errors;
        $display("Errors: decode %0d, scheduler %0d, assertion %0d, other %0d",
                 decode_errors, sched_errors, DUT.u_checker.assert_errors, other_errors);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        seed = 86427;
        void'($urandom(seed));
        rst           = 1'b1;
        fetch_valid   = 1'b0;
        fetch_data    = '0;
        decode_ready  = 1'b0;
        sent          = 0;
        received      = 0;
        pending       = 1'b0;
        decode_errors = 0;
        sched_errors  = 0;
        other_errors  = 0;
        load_vectors();
        if (vec_in.size() == 0) begin
            $display("No test vectors were loaded");
            other_errors++;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (received < vec_in.size()) begin
            @(negedge clk);
            drive_cycle();
            #1;
            observe_cycle();
        end
        @(negedge clk);
        fetch_valid  = 1'b0;
        decode_ready = 1'b0;
        report_results();
    end

    // Watchdog
    initial begin
        wait (loaded);
        #((RESET_CYCLES + CYCLES_PER_VEC * vec_in.size()) * CLK_PERIOD);
        $display("Timeout: %0d of %0d items never emerged from the decode stage",
                 vec_in.size() - received, vec_in.size());
        other_errors++;
        report_results();
    end

endmodule

/* decode_stage_checker.sv */
// Decode stage handshake assertions
`timescale 1ns/1ps

module decode_stage_checker (
    input logic                         clk,
    input logic                         rst,
    input logic                         fetch_ready,
    input logic                         decode_valid,
    input logic                         decode_ready,
    input gpu_decode_pkg::decode_data_t decode_data,
    input logic                         sched_valid
);

    int assert_errors = 0;

    // Stalled output keeps its item
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (decode_valid && !decode_ready) |=> (decode_valid && $stable(decode_data)))
    else begin
        assert_errors++;
        $error("decode output changed while the issue side stalled");
    end

    // Empty buffer accepts right after reset
    ready_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> fetch_ready)
    else begin
        assert_errors++;
        $error("fetch_ready low after reset");
    end

    // Accepted item is on the output one cycle later
    notice_then_output: assert property (@(posedge clk) disable iff (rst)
        sched_valid |=> decode_valid)
    else begin
        assert_errors++;
        $error("accepted item did not reach the decode output");
    end

endmodule

bind decode_stage decode_stage_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .fetch_ready  (fetch_ready),
    .decode_valid (decode_valid),
    .decode_ready (decode_ready),
    .decode_data  (decode_data),
    .sched_valid  (sched_valid)
);

/* decode_stage.sv */
// GPU decode stage
`timescale 1ns/1ps

module decode_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_valid,
    output logic                         fetch_ready,
    input  gpu_decode_pkg::fetch_data_t  fetch_data,
    output logic                         decode_valid,
    input  logic                         decode_ready,
    output gpu_decode_pkg::decode_data_t decode_data,
    output logic                         sched_valid,
    output gpu_decode_pkg::sched_info_t  sched
);

    import gpu_decode_pkg::*;

    imm_set_t       imms;
    func_ops_t      ops;
    decode_fields_t fields;
    decode_data_t   buf_in;

    imm_gen u_imm_gen (
        .instr (fetch_data.instr),
        .imms  (imms)
    );

    func_decode u_func_decode (
        .instr (fetch_data.instr),
        .ops   (ops)
    );

    instr_decoder u_instr_decoder (
        .instr  (fetch_data.instr),
        .imms   (imms),
        .ops    (ops),
        .fields (fields)
    );

    always_comb begin
        buf_in.uuid    = fetch_data.uuid;
        buf_in.wid     = fetch_data.wid;
        buf_in.tmask   = fetch_data.tmask;
        buf_in.pc      = fetch_data.pc;
        buf_in.ex_type = fields.ex_type;
        buf_in.op_type = fields.op_type;
        buf_in.op_args = fields.op_args;
        buf_in.wb      = fields.wb;
        buf_in.rd      = fields.rd;
        buf_in.rs1     = fields.rs1;
        buf_in.rs2     = fields.rs2;
        buf_in.rs3     = fields.rs3;
    end

    decode_buffer u_decode_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (buf_in),
        .out_valid (decode_valid),
        .out_ready (decode_ready),
        .out_data  (decode_data)
    );

    // Scheduler hears about the stall in the transfer cycle
    assign sched_valid     = fetch_valid && fetch_ready;
    assign sched.wid       = fetch_data.wid;
    assign sched.is_wstall = fields.is_wstall;

endmodule

/* decode_buffer.sv */
// Two-entry decode output buffer
`timescale 1ns/1ps

module decode_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  gpu_decode_pkg::decode_data_t in_data,
    output logic                         out_valid,
    input  logic                         out_ready,
    output gpu_decode_pkg::decode_data_t out_data
);

    import gpu_decode_pkg::*;

    decode_data_t mem [2];
    logic         wr_ptr;
    logic         rd_ptr;
    logic [1:0]   count;
    logic         push;
    logic         pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            // Push and pop together keep the count
            case ({push, pop})
                2'b10: count <= count + 2'd1;
                2'b01: count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* instr_decoder.sv */
// Instruction decoder
`timescale 1ns/1ps
`include "gpu_decode_consts.svh"

module instr_decoder (
    input  logic [31:0]                    instr,
    input  gpu_decode_pkg::imm_set_t       imms,
    input  gpu_decode_pkg::func_ops_t      ops,
    output gpu_decode_pkg::decode_fields_t fields
);

    logic [6:0]  opcode;
    logic [2:0]  func3;
    logic [6:0]  func7;
    logic [11:0] u_12;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        use_rd;

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign u_12   = instr[31:20];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        fields         = '0;
        fields.ex_type = `EX_ALU;
        use_rd         = 1'b0;

        case (opcode)
            `INST_I: begin
                fields.op_type              = ops.alu_op;
                fields.op_args.alu.xtype    = `ALU_ARITH;
                fields.op_args.alu.use_imm  = 1'b1;
                fields.op_args.alu.imm      = imms.i_imm;
                use_rd     = 1'b1;
                fields.rs1 = rs1;
            end
            `INST_R: begin
                // func7 of 1 selects the M extension
                if (func7 == 7'h01) begin
                    fields.op_type           = ops.mul_op;
                    fields.op_args.alu.xtype = `ALU_MULDIV;
                end else begin
                    fields.op_type           = ops.alu_op;
                    fields.op_args.alu.xtype = `ALU_ARITH;
                end
                use_rd     = 1'b1;
                fields.rs1 = rs1;
                fields.rs2 = rs2;
            end
            `INST_LUI, `INST_AUIPC: begin
                fields.op_type = opcode[5] ? `OP_ALU_LUI : `OP_ALU_AUIPC;
                fields.op_args.alu.xtype   = `ALU_ARITH;
                fields.op_args.alu.use_pc  = ~opcode[5];
                fields.op_args.alu.use_imm = 1'b1;
                fields.op_args.alu.imm     = imms.u_imm;
                use_rd = 1'b1;
            end
            `INST_JAL: begin
                fields.op_type             = `OP_BR_JAL;
                fields.op_args.alu.xtype   = `ALU_BRANCH;
                fields.op_args.alu.use_pc  = 1'b1;
                fields.op_args.alu.use_imm = 1'b1;
                fields.op_args.alu.imm     = imms.j_imm;
                use_rd           = 1'b1;
                fields.is_wstall = 1'b1;
            end
            `INST_JALR: begin
                fields.op_type             = `OP_BR_JALR;
                fields.op_args.alu.xtype   = `ALU_BRANCH;
                fields.op_args.alu.use_imm = 1'b1;
                fields.op_args.alu.imm     = imms.i_imm;
                use_rd           = 1'b1;
                fields.rs1       = rs1;
                fields.is_wstall = 1'b1;
            end
            `INST_B: begin
                fields.op_type             = ops.br_op;
                fields.op_args.alu.xtype   = `ALU_BRANCH;
                fields.op_args.alu.use_pc  = 1'b1;
                fields.op_args.alu.use_imm = 1'b1;
                fields.op_args.alu.imm     = imms.b_imm;
                fields.rs1       = rs1;
                fields.rs2       = rs2;
                fields.is_wstall = 1'b1;
            end
            `INST_L: begin
                fields.ex_type            = `EX_LSU;
                fields.op_type            = {1'b0, func3};
                fields.op_args.lsu.offset = u_12;
                use_rd     = 1'b1;
                fields.rs1 = rs1;
            end
            `INST_S: begin
                fields.ex_type              = `EX_LSU;
                fields.op_type              = {1'b1, func3};
                fields.op_args.lsu.is_store = 1'b1;
                fields.op_args.lsu.offset   = imms.s_imm[11:0];
                fields.rs1 = rs1;
                fields.rs2 = rs2;
            end
            `INST_FENCE: begin
                fields.ex_type = `EX_LSU;
                fields.op_type = `OP_LSU_FENCE;
            end
            `INST_SYS: begin
                use_rd = 1'b1;
                if (func3[1:0] != 2'b00) begin
                    fields.ex_type = `EX_SFU;
                    fields.op_type = `OP_SFU_CSRRW + `OP_BITS'(func3[1:0]) - 4'd1;
                    fields.op_args.csr.addr    = u_12;
                    fields.op_args.csr.use_imm = func3[2];
                    // Immediate forms carry zimm in the rs1 field
                    if (func3[2]) begin
                        fields.op_args.csr.imm = rs1;
                    end else begin
                        fields.rs1 = rs1;
                    end
                    fields.is_wstall = (u_12 <= `CSR_FCSR);
                end else begin
                    fields.op_type             = ops.sys_op;
                    fields.op_args.alu.xtype   = `ALU_BRANCH;
                    fields.op_args.alu.use_pc  = 1'b1;
                    fields.op_args.alu.use_imm = 1'b1;
                    fields.op_args.alu.imm     = `XLEN'd4;
                    fields.is_wstall = 1'b1;
                end
            end
            `INST_EXT1: begin
                if (func7 == 7'h00 && func3 <= 3'h5) begin
                    fields.ex_type   = `EX_SFU;
                    fields.is_wstall = 1'b1;
                    fields.rs1       = rs1;
                    case (func3)
                        3'h0: fields.op_type = `OP_SFU_TMC;
                        3'h1: begin
                            fields.op_type = `OP_SFU_WSPAWN;
                            fields.rs2     = rs2;
                        end
                        3'h2: begin
                            fields.op_type             = `OP_SFU_SPLIT;
                            fields.op_args.wctl.is_neg = rs2[0];
                            use_rd = 1'b1;
                        end
                        3'h3: fields.op_type = `OP_SFU_JOIN;
                        3'h4: begin
                            fields.op_type = `OP_SFU_BAR;
                            fields.rs2     = rs2;
                        end
                        default: begin
                            fields.op_type             = `OP_SFU_PRED;
                            fields.op_args.wctl.is_neg = rd[0];
                            fields.rs2                 = rs2;
                        end
                    endcase
                end
            end
            default: begin
            end
        endcase

        if (use_rd) begin
            fields.rd = rd;
        end
        // x0 is never written
        fields.wb = use_rd && (rd != '0);
    end

endmodule

/* func_decode.sv */
// Function field decoder
`timescale 1ns/1ps
`include "gpu_decode_consts.svh"

module func_decode (
    input  logic [31:0]               instr,
    output gpu_decode_pkg::func_ops_t ops
);

    logic [2:0]  func3;
    logic [6:0]  func7;
    logic [11:0] sys_field;

    assign func3     = instr[14:12];
    assign func7     = instr[31:25];
    assign sys_field = instr[31:20];

    always_comb begin
        ops = '0;

        case (func3)
            3'h0: ops.alu_op = (instr[5] && func7[5]) ? `OP_ALU_SUB : `OP_ALU_ADD;
            3'h1: ops.alu_op = `OP_ALU_SLL;
            3'h2: ops.alu_op = `OP_ALU_SLT;
            3'h3: ops.alu_op = `OP_ALU_SLTU;
            3'h4: ops.alu_op = `OP_ALU_XOR;
            3'h5: ops.alu_op = func7[5] ? `OP_ALU_SRA : `OP_ALU_SRL;
            3'h6: ops.alu_op = `OP_ALU_OR;
            default: ops.alu_op = `OP_ALU_AND;
        endcase

        // func3 2 and 3 are not branches
        case (func3)
            3'h0: ops.br_op = `OP_BR_EQ;
            3'h1: ops.br_op = `OP_BR_NE;
            3'h4: ops.br_op = `OP_BR_LT;
            3'h5: ops.br_op = `OP_BR_GE;
            3'h6: ops.br_op = `OP_BR_LTU;
            3'h7: ops.br_op = `OP_BR_GEU;
            default: ops.br_op = '0;
        endcase

        case (sys_field)
            12'h000: ops.sys_op = `OP_BR_ECALL;
            12'h001: ops.sys_op = `OP_BR_EBREAK;
            12'h002: ops.sys_op = `OP_BR_URET;
            12'h102: ops.sys_op = `OP_BR_SRET;
            12'h302: ops.sys_op = `OP_BR_MRET;
            default: ops.sys_op = '0;
        endcase

        case (func3)
            3'h0: ops.mul_op = `OP_M_MUL;
            3'h1: ops.mul_op = `OP_M_MULH;
            3'h2: ops.mul_op = `OP_M_MULHSU;
            3'h3: ops.mul_op = `OP_M_MULHU;
            3'h4: ops.mul_op = `OP_M_DIV;
            3'h5: ops.mul_op = `OP_M_DIVU;
            3'h6: ops.mul_op = `OP_M_REM;
            default: ops.mul_op = `OP_M_REMU;
        endcase
    end

endmodule

/* imm_gen.sv */
// Immediate generator
`timescale 1ns/1ps
`include "gpu_decode_consts.svh"

module imm_gen (
    input  logic [31:0]             instr,
    output gpu_decode_pkg::imm_set_t imms
);

    logic [2:0] func3;
    logic       is_shift;

    assign func3 = instr[14:12];

    // SLLI, SRLI, SRAI carry a shift amount
    assign is_shift = (func3[1:0] == 2'b01);

    assign imms.i_imm = is_shift ? {{(`XLEN-5){1'b0}}, instr[24:20]}
                                 : {{(`XLEN-12){instr[31]}}, instr[31:20]};

    assign imms.s_imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    assign imms.b_imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                         instr[30:25], instr[11:8], 1'b0};

    assign imms.j_imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                         instr[20], instr[30:21], 1'b0};

    assign imms.u_imm = {instr[31:12], 12'b0};

endmodule

/* gpu_decode_pkg.sv */
// GPU decode types
`include "gpu_decode_consts.svh"

package gpu_decode_pkg;

    typedef struct packed {
        logic [`UUID_BITS-1:0]   uuid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        logic [31:0]             instr;
    } fetch_data_t;

    typedef struct packed {
        logic [`XLEN-1:0] i_imm;
        logic [`XLEN-1:0] s_imm;
        logic [`XLEN-1:0] b_imm;
        logic [`XLEN-1:0] j_imm;
        logic [`XLEN-1:0] u_imm;
    } imm_set_t;

    typedef struct packed {
        logic [`OP_BITS-1:0] alu_op;
        logic [`OP_BITS-1:0] br_op;
        logic [`OP_BITS-1:0] sys_op;
        logic [`OP_BITS-1:0] mul_op;
    } func_ops_t;

    typedef struct packed {
        logic [1:0]       xtype;
        logic             use_pc;
        logic             use_imm;
        logic [`XLEN-1:0] imm;
    } alu_args_t;

    typedef struct packed {
        logic        is_store;
        logic [11:0] offset;
        logic [22:0] pad;
    } lsu_args_t;

    typedef struct packed {
        logic [11:0] addr;
        logic        use_imm;
        logic [4:0]  imm;
        logic [17:0] pad;
    } csr_args_t;

    typedef struct packed {
        logic        is_neg;
        logic [34:0] pad;
    } wctl_args_t;

    // One argument word, read per unit
    typedef union packed {
        alu_args_t  alu;
        lsu_args_t  lsu;
        csr_args_t  csr;
        wctl_args_t wctl;
    } op_args_t;

    typedef struct packed {
        logic [`EX_BITS-1:0] ex_type;
        logic [`OP_BITS-1:0] op_type;
        op_args_t            op_args;
        logic                wb;
        logic [`NR_BITS-1:0] rd;
        logic [`NR_BITS-1:0] rs1;
        logic [`NR_BITS-1:0] rs2;
        logic [`NR_BITS-1:0] rs3;
        logic                is_wstall;
    } decode_fields_t;

    typedef struct packed {
        logic [`UUID_BITS-1:0]   uuid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        logic [`EX_BITS-1:0]     ex_type;
        logic [`OP_BITS-1:0]     op_type;
        op_args_t                op_args;
        logic                    wb;
        logic [`NR_BITS-1:0]     rd;
        logic [`NR_BITS-1:0]     rs1;
        logic [`NR_BITS-1:0]     rs2;
        logic [`NR_BITS-1:0]     rs3;
    } decode_data_t;

    typedef struct packed {
        logic [`NW_BITS-1:0] wid;
        logic                is_wstall;
    } sched_info_t;

endpackage

/* gpu_decode_consts.svh */
// GPU decode constants
`ifndef GPU_DECODE_CONSTS_SVH
`define GPU_DECODE_CONSTS_SVH

`define XLEN        32
`define UUID_BITS   8
`define NW_BITS     2
`define NUM_THREADS 4
`define NR_BITS     5
`define OP_BITS     4
`define EX_BITS     2

// Execution units
`define EX_ALU 2'd0
`define EX_LSU 2'd1
`define EX_SFU 2'd2

// RISC-V major opcodes
`define INST_I     7'b0010011
`define INST_R     7'b0110011
`define INST_LUI   7'b0110111
`define INST_AUIPC 7'b0010111
`define INST_JAL   7'b1101111
`define INST_JALR  7'b1100111
`define INST_B     7'b1100011
`define INST_L     7'b0000011
`define INST_S     7'b0100011
`define INST_FENCE 7'b0001111
`define INST_SYS   7'b1110011
`define INST_EXT1  7'b0001011

// ALU operation class
`define ALU_ARITH  2'd0
`define ALU_BRANCH 2'd1
`define ALU_MULDIV 2'd2

`define OP_ALU_ADD   4'd0
`define OP_ALU_SUB   4'd1
`define OP_ALU_SLL   4'd2
`define OP_ALU_SLT   4'd3
`define OP_ALU_SLTU  4'd4
`define OP_ALU_XOR   4'd5
`define OP_ALU_SRL   4'd6
`define OP_ALU_SRA   4'd7
`define OP_ALU_OR    4'd8
`define OP_ALU_AND   4'd9
`define OP_ALU_LUI   4'd10
`define OP_ALU_AUIPC 4'd11

// Branch class, system returns included
`define OP_BR_EQ     4'd0
`define OP_BR_NE     4'd1
`define OP_BR_LT     4'd2
`define OP_BR_GE     4'd3
`define OP_BR_LTU    4'd4
`define OP_BR_GEU    4'd5
`define OP_BR_JAL    4'd6
`define OP_BR_JALR   4'd7
`define OP_BR_ECALL  4'd8
`define OP_BR_EBREAK 4'd9
`define OP_BR_URET   4'd10
`define OP_BR_SRET   4'd11
`define OP_BR_MRET   4'd12

`define OP_M_MUL    4'd0
`define OP_M_MULH   4'd1
`define OP_M_MULHSU 4'd2
`define OP_M_MULHU  4'd3
`define OP_M_DIV    4'd4
`define OP_M_DIVU   4'd5
`define OP_M_REM    4'd6
`define OP_M_REMU   4'd7

`define OP_SFU_TMC    4'd0
`define OP_SFU_WSPAWN 4'd1
`define OP_SFU_SPLIT  4'd2
`define OP_SFU_JOIN   4'd3
`define OP_SFU_BAR    4'd4
`define OP_SFU_PRED   4'd5
`define OP_SFU_CSRRW  4'd6
`define OP_SFU_CSRRS  4'd7
`define OP_SFU_CSRRC  4'd8

// Loads use {0,func3}, stores {1,func3}
`define OP_LSU_FENCE 4'd15

// Last floating-point CSR
`define CSR_FCSR 12'h003

`endif
